// ==== dec_params.svh ====
`ifndef DEC_PARAMS_SVH
`define DEC_PARAMS_SVH

// word and register widths
`define XLEN        32
`define REG_ADDR_W  5

// major opcodes, full-width words
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_SYSTEM  7'b1110011

// compressed quadrants (2'b11 is a full-width word)
`define RVC_Q0      2'b00
`define RVC_Q1      2'b01
`define RVC_Q2      2'b10

// machine CSRs known to the core
`define CSR_MISA      12'h301
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342

`define FUNCT12_MRET  12'h302

`define REG_RA      5'd1 // link
`define REG_SP      5'd2 // stack pointer

// downstream issue queue depth
`define DEC_CREDITS 4
`define DEC_CNT_W   $clog2(`DEC_CREDITS + 1)

`endif

// ==== dec_pkg.sv ====
`include "dec_params.svh"

package dec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_SLT, ALU_SLTU, ALU_SEQ, ALU_SNE, ALU_SGE, ALU_SGEU
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS1, SRC1_PC, SRC1_ZERO, SRC1_IMM_CSR} alu_src1_e;
    typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_4_OR_2} alu_src2_e;

    typedef enum logic [3:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_CIW, IMM_CLS, IMM_CI,
        IMM_CJ, IMM_C16, IMM_CLUI, IMM_CB, IMM_CJR, IMM_CSPL, IMM_CSPS
    } imm_type_e;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;
    typedef enum logic [1:0] {PC_NEXT, PC_JAL, PC_JALR, PC_BRANCH} pc_src_e;
    typedef enum logic [1:0] {CSR_READ, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_e;

    //////////////////////////////
    // instruction word, two views
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } instr_full_t;

    typedef struct packed {
        logic [`XLEN/2-1:0]     upper;    // next parcel, ignored
        logic [2:0]             funct3_c;
        logic                   b12;
        logic [`REG_ADDR_W-1:0] rd_rs1;
        logic [`REG_ADDR_W-1:0] rs2_c;
        logic [1:0]             quadrant;
    } instr_comp_t;

    typedef union packed {
        instr_full_t f;
        instr_comp_t c;
    } instr_word_u;

    //////////////////////////////
    // decoder results
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
    } reg_addrs_t;

    typedef struct packed {
        logic    csr_access;
        csr_op_e csr_op;
        logic    csr_imm;  // operand 1 is the rs1 field itself
        logic    is_mret;
        logic    illegal;
    } sys_ctrl_t;

    typedef struct packed {
        alu_op_e    alu_op;
        alu_src1_e  alu_src1;
        alu_src2_e  alu_src2;
        imm_type_e  imm_type;
        reg_addrs_t regs;
        logic       mem_wen;
        mem_size_e  mem_size;
        logic       mem_sign_ext;
        logic       reg_alu_wen;
        logic       reg_mem_wen;
        pc_src_e    pc_src;
        logic       is_branch;
        logic       csr_access;
        csr_op_e    csr_op;
        logic       is_mret;
        logic       is_compressed;
        logic       illegal;
    } dec_ctrl_t;

    // plain add with no side effects, starting point for both decoders
    localparam dec_ctrl_t DEC_CTRL_DEFAULT = '{
        alu_op: ALU_ADD, alu_src1: SRC1_RS1, alu_src2: SRC2_RS2, imm_type: IMM_I,
        regs: '0, mem_wen: 1'b0, mem_size: MEM_WORD, mem_sign_ext: 1'b0,
        reg_alu_wen: 1'b0, reg_mem_wen: 1'b0, pc_src: PC_NEXT, is_branch: 1'b0,
        csr_access: 1'b0, csr_op: CSR_READ, is_mret: 1'b0, is_compressed: 1'b0,
        illegal: 1'b0
    };

endpackage

// ==== system_decoder.sv ====
`timescale 1ns/1ps
`include "dec_params.svh"

module system_decoder (
    input  dec_pkg::instr_word_u instr_i,
    output dec_pkg::sys_ctrl_t   sys_o
);
    import dec_pkg::*;

    logic [11:0] csr_addr;
    logic        rs1_zero;

    assign csr_addr = {instr_i.f.funct7, instr_i.f.rs2}; // funct12 for mret
    assign rs1_zero = (instr_i.f.rs1 == '0);

    always_comb begin
        sys_o = '{csr_access: 1'b0, csr_op: CSR_READ, csr_imm: 1'b0,
                  is_mret: 1'b0, illegal: 1'b0};

        if (instr_i.f.funct3 == 3'b000) begin
            // ecall, ebreak, wfi and friends are not supported
            if (csr_addr == `FUNCT12_MRET && rs1_zero && instr_i.f.rd == '0)
                sys_o.is_mret = 1'b1;
            else
                sys_o.illegal = 1'b1;
        end else begin
            sys_o.csr_access = 1'b1;
            sys_o.csr_imm    = instr_i.f.funct3[2]; // csrr*i

            // set/clear with x0 or zimm 0 never writes
            unique case (instr_i.f.funct3[1:0])
                2'b01:   sys_o.csr_op = CSR_WRITE;
                2'b10:   sys_o.csr_op = rs1_zero ? CSR_READ : CSR_SET;
                2'b11:   sys_o.csr_op = rs1_zero ? CSR_READ : CSR_CLEAR;
                default: sys_o.illegal = 1'b1;
            endcase

            case (csr_addr)
                `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID, `CSR_MHARTID: begin
                    if (sys_o.csr_op != CSR_READ)
                        sys_o.illegal = 1'b1; // read-only ID registers
                end
                `CSR_MISA, `CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC,
                `CSR_MEPC, `CSR_MCAUSE, `CSR_MSCRATCH: ;
                default: sys_o.illegal = 1'b1;
            endcase
        end
    end

endmodule

// ==== rv32_base_decoder.sv ====
`timescale 1ns/1ps
`include "dec_params.svh"

module rv32_base_decoder (
    input  dec_pkg::instr_word_u instr_i,
    output dec_pkg::dec_ctrl_t   ctrl_o
);
    import dec_pkg::*;

    instr_full_t w;
    sys_ctrl_t   sys;

    assign w = instr_i.f;

    system_decoder u_system_decoder (
        .instr_i (instr_i),
        .sys_o   (sys)
    );

    // shared funct3 map of OP and OP-IMM
    function automatic alu_op_e arith_op(input logic [2:0] funct3);
        case (funct3)
            3'b000:  arith_op = ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl_o      = DEC_CTRL_DEFAULT;
        ctrl_o.regs = '{rs1: w.rs1, rs2: w.rs2, rd: w.rd};

        unique case (w.opcode)
            //////////////////////////////
            // alu
            `OPC_OP: begin
                ctrl_o.reg_alu_wen = 1'b1;
                if (w.funct7 == 7'h00)
                    ctrl_o.alu_op = arith_op(w.funct3);
                else if (w.funct7 == 7'h20 && w.funct3 inside {3'b000, 3'b101})
                    ctrl_o.alu_op = w.funct3[2] ? ALU_SRA : ALU_SUB;
                else
                    ctrl_o.illegal = 1'b1;
            end
            `OPC_OP_IMM: begin
                ctrl_o.alu_src2    = SRC2_IMM;
                ctrl_o.reg_alu_wen = 1'b1;
                ctrl_o.alu_op      = arith_op(w.funct3);
                if (w.funct3 == 3'b001 && w.funct7 != 7'h00)
                    ctrl_o.illegal = 1'b1;
                if (w.funct3 == 3'b101) begin
                    if (w.funct7 == 7'h20)
                        ctrl_o.alu_op = ALU_SRA;
                    else if (w.funct7 != 7'h00)
                        ctrl_o.illegal = 1'b1;
                end
            end
            `OPC_LUI, `OPC_AUIPC: begin
                ctrl_o.alu_src1    = w.opcode[5] ? SRC1_ZERO : SRC1_PC;
                ctrl_o.alu_src2    = SRC2_IMM;
                ctrl_o.imm_type    = IMM_U;
                ctrl_o.reg_alu_wen = 1'b1;
            end

            //////////////////////////////
            // loads and stores
            `OPC_LOAD: begin
                ctrl_o.alu_src2     = SRC2_IMM;
                ctrl_o.reg_mem_wen  = 1'b1;
                ctrl_o.mem_sign_ext = !w.funct3[2];
                unique case (w.funct3)
                    3'b000, 3'b100: ctrl_o.mem_size = MEM_BYTE;
                    3'b001, 3'b101: ctrl_o.mem_size = MEM_HALF;
                    3'b010:         ctrl_o.mem_size = MEM_WORD;
                    default:        ctrl_o.illegal  = 1'b1;
                endcase
            end
            `OPC_STORE: begin
                ctrl_o.alu_src2 = SRC2_IMM;
                ctrl_o.imm_type = IMM_S;
                ctrl_o.mem_wen  = 1'b1;
                unique case (w.funct3)
                    3'b000:  ctrl_o.mem_size = MEM_BYTE;
                    3'b001:  ctrl_o.mem_size = MEM_HALF;
                    3'b010:  ctrl_o.mem_size = MEM_WORD;
                    default: ctrl_o.illegal  = 1'b1;
                endcase
            end

            //////////////////////////////
            // control flow
            `OPC_BRANCH: begin
                ctrl_o.imm_type  = IMM_B; // target has its own adder
                ctrl_o.pc_src    = PC_BRANCH;
                ctrl_o.is_branch = 1'b1;
                unique case (w.funct3)
                    3'b000:  ctrl_o.alu_op  = ALU_SEQ;
                    3'b001:  ctrl_o.alu_op  = ALU_SNE;
                    3'b100:  ctrl_o.alu_op  = ALU_SLT;
                    3'b101:  ctrl_o.alu_op  = ALU_SGE;
                    3'b110:  ctrl_o.alu_op  = ALU_SLTU;
                    3'b111:  ctrl_o.alu_op  = ALU_SGEU;
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            `OPC_JAL, `OPC_JALR: begin
                // alu produces the link value pc+4
                ctrl_o.alu_src1    = SRC1_PC;
                ctrl_o.alu_src2    = SRC2_4_OR_2;
                ctrl_o.reg_alu_wen = 1'b1;
                if (w.opcode[3]) begin
                    ctrl_o.imm_type = IMM_J;
                    ctrl_o.pc_src   = PC_JAL;
                end else begin
                    ctrl_o.pc_src  = PC_JALR;
                    ctrl_o.illegal = (w.funct3 != 3'b000);
                end
            end

            `OPC_SYSTEM: begin
                ctrl_o.csr_access = sys.csr_access;
                ctrl_o.csr_op     = sys.csr_op;
                ctrl_o.is_mret    = sys.is_mret;
                ctrl_o.illegal    = sys.illegal;
                if (sys.csr_access) begin
                    ctrl_o.reg_alu_wen = 1'b1; // old csr value to rd
                    ctrl_o.alu_src2    = SRC2_IMM;
                    ctrl_o.alu_src1    = sys.csr_imm ? SRC1_IMM_CSR : SRC1_RS1;
                end
            end

            default: ctrl_o.illegal = 1'b1;
        endcase
    end

endmodule

// ==== rvc_decoder.sv ====
`timescale 1ns/1ps
`include "dec_params.svh"

module rvc_decoder (
    input  dec_pkg::instr_word_u instr_i,
    output dec_pkg::dec_ctrl_t   ctrl_o
);
    import dec_pkg::*;

    instr_comp_t            c;
    logic [`REG_ADDR_W-1:0] rs1_p;     // x8..x15 from bits 9:7
    logic [`REG_ADDR_W-1:0] rs2_p;     // x8..x15 from bits 4:2
    logic                   imm6_zero;

    assign c         = instr_i.c;
    assign rs1_p     = {2'b01, c.rd_rs1[2:0]};
    assign rs2_p     = {2'b01, c.rs2_c[2:0]};
    assign imm6_zero = ({c.b12, c.rs2_c} == 6'd0);

    always_comb begin
        ctrl_o               = DEC_CTRL_DEFAULT;
        ctrl_o.is_compressed = 1'b1;
        ctrl_o.regs          = '{rs1: c.rd_rs1, rs2: c.rs2_c, rd: c.rd_rs1};

        unique case (c.quadrant)
            `RVC_Q0: begin
                ctrl_o.alu_src2 = SRC2_IMM;
                ctrl_o.imm_type = IMM_CLS;
                ctrl_o.regs     = '{rs1: rs1_p, rs2: rs2_p, rd: rs2_p};
                unique case (c.funct3_c)
                    3'b000: begin // c.addi4spn
                        ctrl_o.imm_type    = IMM_CIW;
                        ctrl_o.reg_alu_wen = 1'b1;
                        ctrl_o.regs.rs1    = `REG_SP;
                        ctrl_o.illegal     = ({c.b12, c.rd_rs1, c.rs2_c[4:3]} == 8'd0);
                    end
                    3'b010:  ctrl_o.reg_mem_wen = 1'b1; // c.lw
                    3'b110:  ctrl_o.mem_wen     = 1'b1; // c.sw
                    default: ctrl_o.illegal     = 1'b1;
                endcase
            end

            `RVC_Q1: begin
                unique case (c.funct3_c)
                    3'b000, 3'b010: begin // c.addi, c.li
                        ctrl_o.alu_src1    = c.funct3_c[1] ? SRC1_ZERO : SRC1_RS1;
                        ctrl_o.alu_src2    = SRC2_IMM;
                        ctrl_o.imm_type    = IMM_CI;
                        ctrl_o.reg_alu_wen = 1'b1;
                    end
                    3'b001, 3'b101: begin // c.jal, c.j
                        ctrl_o.alu_src1 = SRC1_PC;
                        ctrl_o.imm_type = IMM_CJ;
                        ctrl_o.pc_src   = PC_JAL;
                        if (!c.funct3_c[2]) begin
                            ctrl_o.alu_src2    = SRC2_4_OR_2; // link pc+2
                            ctrl_o.reg_alu_wen = 1'b1;
                            ctrl_o.regs.rd     = `REG_RA;
                        end
                    end
                    3'b011: begin // c.addi16sp or c.lui
                        ctrl_o.alu_src2    = SRC2_IMM;
                        ctrl_o.reg_alu_wen = 1'b1;
                        ctrl_o.illegal     = imm6_zero;
                        if (c.rd_rs1 == `REG_SP) begin
                            ctrl_o.imm_type = IMM_C16;
                        end else begin
                            ctrl_o.alu_src1 = SRC1_ZERO;
                            ctrl_o.imm_type = IMM_CLUI;
                        end
                    end
                    3'b100: begin
                        ctrl_o.reg_alu_wen = 1'b1;
                        ctrl_o.regs        = '{rs1: rs1_p, rs2: rs2_p, rd: rs1_p};
                        if (c.rd_rs1[4:3] != 2'b11) begin // srli, srai, andi
                            ctrl_o.alu_src2 = SRC2_IMM;
                            ctrl_o.imm_type = IMM_CI;
                            unique case (c.rd_rs1[4:3])
                                2'b00:   ctrl_o.alu_op = ALU_SRL;
                                2'b01:   ctrl_o.alu_op = ALU_SRA;
                                default: ctrl_o.alu_op = ALU_AND;
                            endcase
                            // shamt[5] must be zero on rv32
                            ctrl_o.illegal = c.b12 && !c.rd_rs1[4];
                        end else begin
                            ctrl_o.illegal = c.b12;
                            unique case (c.rs2_c[4:3])
                                2'b00:   ctrl_o.alu_op = ALU_SUB;
                                2'b01:   ctrl_o.alu_op = ALU_XOR;
                                2'b10:   ctrl_o.alu_op = ALU_OR;
                                default: ctrl_o.alu_op = ALU_AND;
                            endcase
                        end
                    end
                    default: begin // c.beqz, c.bnez
                        ctrl_o.alu_op    = c.funct3_c[0] ? ALU_SNE : ALU_SEQ;
                        ctrl_o.imm_type  = IMM_CB;
                        ctrl_o.pc_src    = PC_BRANCH;
                        ctrl_o.is_branch = 1'b1;
                        ctrl_o.regs.rs1  = rs1_p;
                        ctrl_o.regs.rs2  = '0;
                    end
                endcase
            end

            `RVC_Q2: begin
                unique case (c.funct3_c)
                    3'b000: begin // c.slli
                        ctrl_o.alu_op      = ALU_SLL;
                        ctrl_o.alu_src2    = SRC2_IMM;
                        ctrl_o.imm_type    = IMM_CI;
                        ctrl_o.reg_alu_wen = 1'b1;
                        ctrl_o.illegal     = c.b12;
                    end
                    3'b010, 3'b110: begin // c.lwsp, c.swsp
                        ctrl_o.alu_src2 = SRC2_IMM;
                        ctrl_o.regs.rs1 = `REG_SP;
                        if (c.funct3_c[2]) begin
                            ctrl_o.imm_type = IMM_CSPS;
                            ctrl_o.mem_wen  = 1'b1;
                        end else begin
                            ctrl_o.imm_type    = IMM_CSPL;
                            ctrl_o.reg_mem_wen = 1'b1;
                            ctrl_o.illegal     = (c.rd_rs1 == '0);
                        end
                    end
                    3'b100: begin
                        if (c.rs2_c != '0) begin // c.mv, c.add
                            ctrl_o.alu_src1    = c.b12 ? SRC1_RS1 : SRC1_ZERO;
                            ctrl_o.reg_alu_wen = 1'b1;
                        end else if (!c.b12) begin // c.jr
                            ctrl_o.alu_src1 = SRC1_PC;
                            ctrl_o.imm_type = IMM_CJR;
                            ctrl_o.pc_src   = PC_JALR;
                            ctrl_o.illegal  = (c.rd_rs1 == '0);
                        end else if (c.rd_rs1 != '0) begin // c.jalr
                            ctrl_o.alu_src1    = SRC1_PC;
                            ctrl_o.alu_src2    = SRC2_4_OR_2;
                            ctrl_o.imm_type    = IMM_CJR;
                            ctrl_o.reg_alu_wen = 1'b1;
                            ctrl_o.pc_src      = PC_JALR;
                            ctrl_o.regs.rd     = `REG_RA;
                        end
                        // c.ebreak left as a nop
                    end
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end

            default: ctrl_o.illegal = 1'b1; // full-width word
        endcase
    end

    // address always built from a base plus immediate
    always_comb begin
        if (!ctrl_o.illegal && (ctrl_o.mem_wen || ctrl_o.reg_mem_wen))
            assert (ctrl_o.alu_src2 == SRC2_IMM)
            else $error("rvc memory access without immediate operand");
    end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`include "dec_params.svh"

module decode_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 instr_valid_i,
    input  dec_pkg::instr_word_u instr_i,
    output logic                 instr_ready_o,
    output logic                 dec_valid_o,
    output dec_pkg::dec_ctrl_t   dec_o,
    input  logic                 credit_return_i
);
    import dec_pkg::*;

    dec_ctrl_t              base_ctrl;
    dec_ctrl_t              rvc_ctrl;
    dec_ctrl_t              dec_next;
    logic                   accept;
    logic [`DEC_CNT_W-1:0]  credits; // free slots downstream

    rv32_base_decoder u_base_decoder (
        .instr_i (instr_i),
        .ctrl_o  (base_ctrl)
    );

    rvc_decoder u_rvc_decoder (
        .instr_i (instr_i),
        .ctrl_o  (rvc_ctrl)
    );

    // low bits other than 11 mean a 16-bit parcel
    assign dec_next      = (instr_i.c.quadrant != 2'b11) ? rvc_ctrl : base_ctrl;
    assign instr_ready_o = (credits != '0);
    assign accept        = instr_valid_i && instr_ready_o;

    //////////////////////////////
    // credits and valid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credits     <= (`DEC_CNT_W)'(`DEC_CREDITS);
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= accept;
            if (accept && !credit_return_i)
                credits <= credits - 1'b1;
            else if (!accept && credit_return_i)
                credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept)
            dec_o <= dec_next;
    end

    //////////////////////////////
    // checks
    credit_overflow_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_return_i |-> credits != (`DEC_CNT_W)'(`DEC_CREDITS))
        else $error("credit returned with no result outstanding");

    credit_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credits <= (`DEC_CNT_W)'(`DEC_CREDITS));

    // last credit spent and none back, so the next cycle must stall
    no_accept_at_zero_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        accept && credits == 1 && !credit_return_i |=> !instr_ready_o && !accept);

endmodule

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps
`include "dec_params.svh"

module tb_decode_stage;
    import dec_pkg::*;

    localparam int NUM_TESTS = 23;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 instr_valid_i;
    instr_word_u          instr_i;
    logic                 instr_ready_o;
    logic                 dec_valid_o;
    dec_ctrl_t            dec_o;
    logic                 credit_return_i;

    string       names [NUM_TESTS];
    logic [31:0] words [NUM_TESTS];
    dec_ctrl_t   exps  [NUM_TESTS];
    int          n_entries;
    int          exp_q[$];
    int          acc_cnt;
    int          rx_cnt;
    int          outstanding;
    logic        prev_accept;
    logic        hold_credits;
    logic [31:0] lcg_state;

    decode_stage u_dut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .instr_ready_o   (instr_ready_o),
        .dec_valid_o     (dec_valid_o),
        .dec_o           (dec_o),
        .credit_return_i (credit_return_i)
    );

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // expected control word built field by field
    function automatic dec_ctrl_t expect_ctrl(
        input alu_op_e a, input alu_src1_e s1, input alu_src2_e s2, input imm_type_e imm,
        input int rs1, input int rs2, input int rd,
        input logic mwen, input mem_size_e sz, input logic sext,
        input logic awen, input logic mrwen, input pc_src_e pc, input logic br,
        input logic csr, input csr_op_e cop, input logic mret, input logic comp);
        dec_ctrl_t e;
        e = '{alu_op: a, alu_src1: s1, alu_src2: s2, imm_type: imm,
              regs: '{rs1: rs1[4:0], rs2: rs2[4:0], rd: rd[4:0]},
              mem_wen: mwen, mem_size: sz, mem_sign_ext: sext,
              reg_alu_wen: awen, reg_mem_wen: mrwen, pc_src: pc, is_branch: br,
              csr_access: csr, csr_op: cop, is_mret: mret, is_compressed: comp,
              illegal: 1'b0};
        return e;
    endfunction

    // only the illegal flag matters for these
    function automatic dec_ctrl_t expect_illegal();
        dec_ctrl_t e;
        e = '0;
        e.illegal = 1'b1;
        return e;
    endfunction

    task automatic add_entry(input string name, input logic [31:0] word, input dec_ctrl_t e);
        names[n_entries] = name;
        words[n_entries] = word;
        exps[n_entries]  = e;
        n_entries++;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic build_table();
        ////////////////////////////////
        // full-width words
        add_entry("add", 32'h002081B3, expect_ctrl(ALU_ADD, SRC1_RS1, SRC2_RS2, IMM_I,
            1, 2, 3, 0, MEM_WORD, 0, 1, 0, PC_NEXT, 0, 0, CSR_READ, 0, 0));
        add_entry("sra", 32'h407352B3, expect_ctrl(ALU_SRA, SRC1_RS1, SRC2_RS2, IMM_I,
            6, 7, 5, 0, MEM_WORD, 0, 1, 0, PC_NEXT, 0, 0, CSR_READ, 0, 0));
        add_entry("addi", 32'hFFF10093, expect_ctrl(ALU_ADD, SRC1_RS1, SRC2_IMM, IMM_I,
            2, 31, 1, 0, MEM_WORD, 0, 1, 0, PC_NEXT, 0, 0, CSR_READ, 0, 0));
        add_entry("lui", 32'h00001237, expect_ctrl(ALU_ADD, SRC1_ZERO, SRC2_IMM, IMM_U,
            0, 0, 4, 0, MEM_WORD, 0, 1, 0, PC_NEXT, 0, 0, CSR_READ, 0, 0));
        add_entry("auipc", 32'h00002297, expect_ctrl(ALU_ADD, SRC1_PC, SRC2_IMM, IMM_U,
            0, 0, 5, 0, MEM_WORD, 0, 1, 0, PC_NEXT, 0, 0, CSR_READ, 0, 0));
        add_entry("lbu", 32'h0043C303, expect_ctrl(ALU_ADD, SRC1_RS1, SRC2_IMM, IMM_I,
            7, 4, 6, 0, MEM_BYTE, 0, 0, 1, PC_NEXT, 0, 0, CSR_READ, 0, 0));
        add_entry("lh", 32'h00039303, expect_ctrl(ALU_ADD, SRC1_RS1, SRC2_IMM, IMM_I,
            7, 0, 6, 0, MEM_HALF, 1, 0, 1, PC_NEXT, 0, 0, CSR_READ, 0, 0));
        add_entry("sw", 32'h00952423, expect_ctrl(ALU_ADD, SRC1_RS1, SRC2_IMM, IMM_S,
            10, 9, 8, 1, MEM_WORD, 0, 0, 0, PC_NEXT, 0, 0, CSR_READ, 0, 0));
        add_entry("bne", 32'h00209063, expect_ctrl(ALU_SNE, SRC1_RS1, SRC2_RS2, IMM_B,
            1, 2, 0, 0, MEM_WORD, 0, 0, 0, PC_BRANCH, 1, 0, CSR_READ, 0, 0));
        add_entry("jal", 32'h000000EF, expect_ctrl(ALU_ADD, SRC1_PC, SRC2_4_OR_2, IMM_J,
            0, 0, 1, 0, MEM_WORD, 0, 1, 0, PC_JAL, 0, 0, CSR_READ, 0, 0));
        add_entry("jalr", 32'h00008067, expect_ctrl(ALU_ADD, SRC1_PC, SRC2_4_OR_2, IMM_I,
            1, 0, 0, 0, MEM_WORD, 0, 1, 0, PC_JALR, 0, 0, CSR_READ, 0, 0));
        add_entry("csrrs_x0", 32'h300022F3, expect_ctrl(ALU_ADD, SRC1_RS1, SRC2_IMM, IMM_I,
            0, 0, 5, 0, MEM_WORD, 0, 1, 0, PC_NEXT, 0, 1, CSR_READ, 0, 0));
        add_entry("mret", 32'h30200073, expect_ctrl(ALU_ADD, SRC1_RS1, SRC2_RS2, IMM_I,
            0, 2, 0, 0, MEM_WORD, 0, 0, 0, PC_NEXT, 0, 0, CSR_READ, 1, 0));
        add_entry("csrw_mhartid", 32'hF1409073, expect_illegal());
        add_entry("csr_unknown", 32'h7C009073, expect_illegal());
        add_entry("ecall", 32'h00000073, expect_illegal());
        add_entry("op_bad_funct7", 32'h022081B3, expect_illegal());
        add_entry("opc_unknown", 32'h0000000B, expect_illegal());
        add_entry("all_zero", 32'h00000000, expect_illegal());
        ////////////////////////////////
        // compressed words
        add_entry("c_lw", 32'h00004104, expect_ctrl(ALU_ADD, SRC1_RS1, SRC2_IMM, IMM_CLS,
            10, 9, 9, 0, MEM_WORD, 0, 0, 1, PC_NEXT, 0, 0, CSR_READ, 0, 1));
        add_entry("c_lwsp", 32'h00004402, expect_ctrl(ALU_ADD, SRC1_RS1, SRC2_IMM, IMM_CSPL,
            2, 0, 8, 0, MEM_WORD, 0, 0, 1, PC_NEXT, 0, 0, CSR_READ, 0, 1));
        add_entry("c_jal", 32'h00002001, expect_ctrl(ALU_ADD, SRC1_PC, SRC2_4_OR_2, IMM_CJ,
            0, 0, 1, 0, MEM_WORD, 0, 1, 0, PC_JAL, 0, 0, CSR_READ, 0, 1));
        add_entry("c_srli_b12", 32'h00009005, expect_illegal());
    endtask

    // accepted words and returned results sampled at each clock edge
    always @(posedge clk_i) begin
        int j;
        if (rst_n_i) begin
            check_value("valid_timing", 64'(prev_accept), 64'(dec_valid_o));
            if (dec_valid_o) begin
                j = exp_q.pop_front();
                if (exps[j].illegal)
                    check_value(names[j], 64'(1'b1), 64'(dec_o.illegal));
                else
                    check_value(names[j], 64'(exps[j]), 64'(dec_o));
                rx_cnt++;
            end
            prev_accept = instr_valid_i && instr_ready_o;
            if (credit_return_i)
                outstanding--;
            if (prev_accept) begin
                exp_q.push_back(acc_cnt);
                acc_cnt++;
                outstanding++;
            end
            lcg_state = lcg_next(lcg_state);
            credit_return_i <= !hold_credits && outstanding > 0 && lcg_state[16];
        end
    end

    task automatic drive_all();
        int i;
        i = 0;
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= words[0];
        while (i < n_entries) begin
            @(posedge clk_i);
            if (instr_ready_o) begin // word taken at this edge
                i++;
                if (i < n_entries)
                    instr_i <= words[i];
                else
                    instr_valid_i <= 1'b0;
            end
        end
    endtask

    // queue depth bounds acceptance while no credits come back
    task automatic check_backpressure();
        while (instr_ready_o !== 1'b0)
            @(posedge clk_i);
        repeat (3) @(posedge clk_i);
        check_value("credits_accepted", 64'(`DEC_CREDITS), 64'(acc_cnt));
        check_value("ready_low", 64'(1'b0), 64'(instr_ready_o));
        hold_credits = 1'b0;
    endtask

    initial begin
        #(NUM_TESTS * 20 * 20ns + 400ns);
        $display("timeout, the DUT stopped returning results");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        instr_valid_i   = 1'b0;
        instr_i         = '0;
        credit_return_i = 1'b0;
        n_entries       = 0;
        acc_cnt         = 0;
        rx_cnt          = 0;
        outstanding     = 0;
        prev_accept     = 1'b0;
        hold_credits    = 1'b1;
        lcg_state       = 32'd70;
        build_table();
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        check_value("ready_after_reset", 64'(1'b1), 64'(instr_ready_o));
        fork
            drive_all();
            check_backpressure();
        join
        while (rx_cnt < n_entries)
            @(posedge clk_i);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
dec_pkg.sv
system_decoder.sv
rv32_base_decoder.sv
rvc_decoder.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf $(BUILD_DIR)
